//--- include/wload_settings.svh
`ifndef WLOAD_SETTINGS_SVH
`define WLOAD_SETTINGS_SVH

// widths
`define WLOAD_DDR_ADDR_W 32
`define WLOAD_DATA_W 64
`define WLOAD_APB_ADDR_W 8

// weight buffer, one tile at most
`define WLOAD_BUF_DEPTH 1024
`define WLOAD_BUF_ADDR_W 10

// output channels per tile
`define WLOAD_ROWS_MODE0 64
`define WLOAD_ROWS_MODE1 128

// outstanding requests towards ddr
`define WLOAD_REQ_DEPTH 8

// apb register map
`define WLOAD_REG_CTRL 8'h00
`define WLOAD_REG_NKK 8'h04
`define WLOAD_REG_OF 8'h08
`define WLOAD_REG_BASE 8'h0C
`define WLOAD_REG_STATUS 8'h10

`endif

//--- design/wload_pkg.sv
`include "wload_settings.svh"

package wload_pkg;

  ////////////////////////////////////////
  // address and data types
  ////////////////////////////////////////

  // ddr word address
  typedef logic [`WLOAD_DDR_ADDR_W-1:0] ddr_addr_t;

  // one weight word
  typedef logic [`WLOAD_DATA_W-1:0] wt_word_t;

  // weight buffer address
  typedef logic [`WLOAD_BUF_ADDR_W-1:0] buf_addr_t;

  ////////////////////////////////////////
  // layer configuration
  ////////////////////////////////////////

  // nif * k * k, words per tile
  typedef logic [31:0] nkk_t;

  // output channel count
  typedef logic [15:0] ofc_t;

  // selects rows per tile
  typedef enum logic {
    MODE0 = 1'b0,
    MODE1 = 1'b1
  } wload_mode_e;

endpackage

//--- design/wload_apb_regs.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module wload_apb_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`WLOAD_APB_ADDR_W-1:0]  paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          busy,
  input  logic                          load_done,
  output logic                          start,
  output wload_pkg::wload_mode_e        cfg_mode,
  output wload_pkg::nkk_t               cfg_nkk,
  output wload_pkg::ofc_t               cfg_of,
  output wload_pkg::ddr_addr_t          cfg_base
);
  logic wr_access;
  logic start_req;
  logic start_bad;
  logic done_q;

  ////////////////////////////////////////
  // access decode
  ////////////////////////////////////////

  assign pready    = 1'b1;
  assign wr_access = psel && penable && pwrite;
  assign start_req = wr_access && (paddr == `WLOAD_REG_CTRL) && pwdata[0];

  // pending start counts as busy too
  assign start_bad = busy || start || (cfg_nkk == '0) || (cfg_nkk > `WLOAD_BUF_DEPTH);
  assign pslverr   = start_req && start_bad;

  always_ff @(posedge clk) begin
    if (reset) begin
      start    <= 1'b0;
      cfg_mode <= wload_pkg::MODE0;
      cfg_nkk  <= '0;
      cfg_of   <= '0;
      cfg_base <= '0;
    end else begin
      start <= start_req && !start_bad;
      if (wr_access) begin
        case (paddr)
          // a rejected start leaves the mode alone
          `WLOAD_REG_CTRL: if (!pslverr) cfg_mode <= wload_pkg::wload_mode_e'(pwdata[1]);
          `WLOAD_REG_NKK:  cfg_nkk  <= pwdata;
          `WLOAD_REG_OF:   cfg_of   <= pwdata[15:0];
          `WLOAD_REG_BASE: cfg_base <= wload_pkg::ddr_addr_t'(pwdata);
          default: ;
        endcase
      end
    end
  end

  // sticky done where set wins over clear
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else if (load_done) begin
      done_q <= 1'b1;
    end else if (wr_access && (paddr == `WLOAD_REG_STATUS) && pwdata[1]) begin
      done_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  always_comb begin
    case (paddr)
      `WLOAD_REG_CTRL:   prdata = {30'd0, cfg_mode, 1'b0};
      `WLOAD_REG_NKK:    prdata = cfg_nkk;
      `WLOAD_REG_OF:     prdata = {16'd0, cfg_of};
      `WLOAD_REG_BASE:   prdata = 32'(cfg_base);
      `WLOAD_REG_STATUS: prdata = {30'd0, done_q, busy};
      default:           prdata = '0;
    endcase
  end

  // apb access phase only inside a selected transfer
  a_enable_needs_sel: assert property (
    @(posedge clk) disable iff (reset) penable |-> psel
  );

endmodule

//--- design/conv_load_weights_controller.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module conv_load_weights_controller (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  wload_pkg::wload_mode_e  cfg_mode,
  input  wload_pkg::nkk_t         cfg_nkk,
  input  wload_pkg::ofc_t         cfg_of,
  input  wload_pkg::ddr_addr_t    cfg_base,
  input  logic                    req_full,
  output logic                    req_push,
  output wload_pkg::ddr_addr_t    req_addr,
  input  logic                    ddr_rd_valid,
  output logic                    buf_wr_en,
  output wload_pkg::buf_addr_t    buf_wr_addr,
  output logic                    busy,
  output logic                    load_done
);
  // layer config captured at start
  wload_pkg::wload_mode_e mode_q;
  wload_pkg::nkk_t        nkk_q;
  wload_pkg::ofc_t        of_q;
  wload_pkg::ddr_addr_t   base_q;

  logic                   issuing;
  wload_pkg::nkk_t        req_cnt;
  logic                   req_last;

  wload_pkg::ofc_t        chan_start;
  wload_pkg::ddr_addr_t   tile_base;
  wload_pkg::ofc_t        row_num;
  logic [$bits(wload_pkg::ofc_t):0] chan_sum;
  logic                   tile_wrap;

  wload_pkg::nkk_t        wr_cnt;
  logic                   wr_last;

  always_ff @(posedge clk) begin
    if (start) begin
      mode_q <= cfg_mode;
      nkk_q  <= cfg_nkk;
      of_q   <= cfg_of;
      base_q <= cfg_base;
    end
  end

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  assign req_push = issuing && !req_full;
  assign req_last = req_push && (req_cnt == nkk_q);
  assign req_addr = base_q + tile_base + wload_pkg::ddr_addr_t'(req_cnt - 32'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      issuing <= 1'b0;
      req_cnt <= 32'd1;
    end else begin
      if (start) begin
        issuing <= 1'b1;
      end else if (req_last) begin
        issuing <= 1'b0;
      end
      // counts 1..N
      if (req_push) begin
        req_cnt <= req_last ? 32'd1 : req_cnt + 32'd1;
      end
    end
  end

  ////////////////////////////////////////
  // tile advance
  ////////////////////////////////////////

  assign row_num   = (mode_q == wload_pkg::MODE1) ? wload_pkg::ofc_t'(`WLOAD_ROWS_MODE1)
                                                  : wload_pkg::ofc_t'(`WLOAD_ROWS_MODE0);
  assign chan_sum  = {1'b0, chan_start} + {1'b0, row_num};
  // wrap once the next tile would run past the last channel
  assign tile_wrap = (chan_sum + {1'b0, row_num}) > {1'b0, of_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      chan_start <= '0;
      tile_base  <= '0;
    end else if (req_last) begin
      if (tile_wrap) begin
        // all output channels covered so back to tile 0
        chan_start <= '0;
        tile_base  <= '0;
      end else begin
        chan_start <= chan_sum[$bits(wload_pkg::ofc_t)-1:0];
        tile_base  <= tile_base + wload_pkg::ddr_addr_t'(nkk_q);
      end
    end
  end

  ////////////////////////////////////////
  // return side
  ////////////////////////////////////////

  assign wr_last     = ddr_rd_valid && (wr_cnt == nkk_q - 32'd1);
  assign buf_wr_en   = ddr_rd_valid;
  assign buf_wr_addr = wload_pkg::buf_addr_t'(wr_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt    <= '0;
      load_done <= 1'b0;
      busy      <= 1'b0;
    end else begin
      if (ddr_rd_valid) begin
        wr_cnt <= wr_last ? '0 : wr_cnt + 32'd1;
      end
      load_done <= wr_last;
      if (start) begin
        busy <= 1'b1;
      end else if (load_done) begin
        busy <= 1'b0;
      end
    end
  end

  // ddr returns only words of the running load
  a_valid_only_busy: assert property (
    @(posedge clk) disable iff (reset) ddr_rd_valid |-> busy
  );

endmodule

//--- design/ddr_req_fifo.sv
`timescale 1ns/1ps

module ddr_req_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  wload_pkg::ddr_addr_t  push_addr,
  output logic                  full,
  output logic                  ddr_rd_en,
  output wload_pkg::ddr_addr_t  ddr_rd_addr,
  input  logic                  ddr_rd_ready
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  wload_pkg::ddr_addr_t mem [DEPTH];
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  logic [CW-1:0]        count;
  logic                 do_push;
  logic                 do_pop;

  // fall-through head shown directly
  assign full        = (count == CW'(DEPTH));
  assign ddr_rd_en   = (count != '0);
  assign ddr_rd_addr = mem[rd_ptr];

  assign do_push = push && !full;
  assign do_pop  = ddr_rd_en && ddr_rd_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  // a push into a full queue would lose an address
  a_no_push_full: assert property (
    @(posedge clk) disable iff (reset) push |-> !full
  );

endmodule

//--- design/weight_buffer.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module weight_buffer (
  input  logic                  clk,
  input  logic                  wr_en,
  input  wload_pkg::buf_addr_t  wr_addr,
  input  wload_pkg::wt_word_t   wr_data,
  input  logic                  rd_en,
  input  wload_pkg::buf_addr_t  rd_addr,
  output wload_pkg::wt_word_t   rd_data
);
  ////////////////////////////////////////
  // weight storage
  ////////////////////////////////////////

  wload_pkg::wt_word_t mem [`WLOAD_BUF_DEPTH];

  // write port, filled by ddr returns
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port for compute engine
  // data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- design/wload_top.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module wload_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`WLOAD_APB_ADDR_W-1:0]  paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          ddr_rd_en,
  output wload_pkg::ddr_addr_t          ddr_rd_addr,
  input  logic                          ddr_rd_ready,
  input  logic                          ddr_rd_valid,
  input  wload_pkg::wt_word_t           ddr_rd_data,
  input  logic                          buf_rd_en,
  input  wload_pkg::buf_addr_t          buf_rd_addr,
  output wload_pkg::wt_word_t           buf_rd_data,
  output logic                          load_done
);
  logic                   start;
  logic                   busy;
  wload_pkg::wload_mode_e cfg_mode;
  wload_pkg::nkk_t        cfg_nkk;
  wload_pkg::ofc_t        cfg_of;
  wload_pkg::ddr_addr_t   cfg_base;
  logic                   req_push;
  logic                   req_full;
  wload_pkg::ddr_addr_t   req_addr;
  logic                   buf_wr_en;
  wload_pkg::buf_addr_t   buf_wr_addr;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  wload_apb_regs u_regs (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .busy(busy), .load_done(load_done), .start(start),
    .cfg_mode(cfg_mode), .cfg_nkk(cfg_nkk), .cfg_of(cfg_of), .cfg_base(cfg_base)
  );

  ////////////////////////////////////////
  // load control and request queue
  ////////////////////////////////////////

  conv_load_weights_controller u_ctrl (
    .clk(clk), .reset(reset), .start(start),
    .cfg_mode(cfg_mode), .cfg_nkk(cfg_nkk), .cfg_of(cfg_of), .cfg_base(cfg_base),
    .req_full(req_full), .req_push(req_push), .req_addr(req_addr),
    .ddr_rd_valid(ddr_rd_valid), .buf_wr_en(buf_wr_en), .buf_wr_addr(buf_wr_addr),
    .busy(busy), .load_done(load_done)
  );

  ddr_req_fifo #(.DEPTH(`WLOAD_REQ_DEPTH)) u_req_fifo (
    .clk(clk), .reset(reset), .push(req_push), .push_addr(req_addr), .full(req_full),
    .ddr_rd_en(ddr_rd_en), .ddr_rd_addr(ddr_rd_addr), .ddr_rd_ready(ddr_rd_ready)
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  weight_buffer u_wbuf (
    .clk(clk),
    .wr_en(buf_wr_en), .wr_addr(buf_wr_addr), .wr_data(ddr_rd_data),
    .rd_en(buf_rd_en), .rd_addr(buf_rd_addr), .rd_data(buf_rd_data)
  );

endmodule

//--- testbench/wload_checker.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module wload_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ddr_rd_en,
  input  logic                  ddr_rd_ready,
  input  wload_pkg::ddr_addr_t  ddr_rd_addr,
  input  logic                  req_allowed,
  input  wload_pkg::ddr_addr_t  exp_addr,
  input  logic                  buf_rd_en,
  input  wload_pkg::wt_word_t   buf_rd_data,
  input  wload_pkg::wt_word_t   exp_data,
  output int                    error_count
);
  int   errs = 0;
  logic rd_pending;

  assign error_count = errs;

  always @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else begin
      // each ddr handshake is one accepted request
      if (ddr_rd_en && ddr_rd_ready) begin
        if (!req_allowed) begin
          $display("%0t: ddr request to %h accepted while no load expects one",
                   $time, ddr_rd_addr);
          errs++;
        end else if (ddr_rd_addr !== exp_addr) begin
          $display("[ERROR] %0t ddr_rd_addr expected %h actual %h",
                   $time, exp_addr, ddr_rd_addr);
          errs++;
        end
      end

      // read data one cycle after rd_en
      rd_pending <= buf_rd_en;
      if (rd_pending && (buf_rd_data !== exp_data)) begin
        $display("[ERROR] %0t buf_rd_data expected %h actual %h",
                 $time, exp_data, buf_rd_data);
        errs++;
      end
    end
  end

endmodule

//--- testbench/wload_tb.sv
`timescale 1ns/1ps
`include "wload_settings.svh"

module wload_tb;
  localparam int SEED         = 32'hf09;
  localparam int APB_TIMEOUT  = 16;
  localparam int LOAD_TIMEOUT = 4000;

  logic                          clk;
  logic                          reset;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`WLOAD_APB_ADDR_W-1:0]  paddr;
  logic [31:0]                   pwdata;
  logic [31:0]                   prdata;
  logic                          pready;
  logic                          pslverr;
  logic                          ddr_rd_en;
  wload_pkg::ddr_addr_t          ddr_rd_addr;
  logic                          ddr_rd_ready = 1'b0;
  logic                          ddr_rd_valid = 1'b0;
  wload_pkg::wt_word_t           ddr_rd_data = '0;
  logic                          buf_rd_en;
  wload_pkg::buf_addr_t          buf_rd_addr;
  wload_pkg::buf_addr_t          rd_ref;
  wload_pkg::wt_word_t           buf_rd_data;
  logic                          load_done;

  // ddr model
  logic                 rand_mode;
  wload_pkg::ddr_addr_t ret_q[$];
  int                   accepted = 0;

  // expected load and tile walk
  logic                 loading;
  int                   idx_origin;
  wload_pkg::ddr_addr_t cur_base;
  int                   cur_nkk;
  int                   cur_of;
  int                   cur_tile;
  int                   chan_start;
  int                   next_tile;
  int                   req_idx;
  logic                 req_allowed;
  wload_pkg::ddr_addr_t exp_addr;
  wload_pkg::wt_word_t  exp_data;
  int                   tb_errors;
  int                   chk_errors;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic wload_pkg::wt_word_t mem_word(wload_pkg::ddr_addr_t a);
    return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]}};
  endfunction

  function automatic wload_pkg::ddr_addr_t expected_addr(wload_pkg::ddr_addr_t base,
                                                         int n, int tile, int j);
    return base + wload_pkg::ddr_addr_t'(tile * n + j);
  endfunction

  assign req_idx     = accepted - idx_origin;
  assign req_allowed = loading && (req_idx < cur_nkk);
  assign exp_addr    = expected_addr(cur_base, cur_nkk, cur_tile, req_idx);
  assign exp_data    = mem_word(expected_addr(cur_base, cur_nkk, cur_tile, int'(rd_ref)));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  wload_top DUT (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ddr_rd_en(ddr_rd_en), .ddr_rd_addr(ddr_rd_addr), .ddr_rd_ready(ddr_rd_ready),
    .ddr_rd_valid(ddr_rd_valid), .ddr_rd_data(ddr_rd_data),
    .buf_rd_en(buf_rd_en), .buf_rd_addr(buf_rd_addr), .buf_rd_data(buf_rd_data),
    .load_done(load_done)
  );

  wload_checker u_check (
    .clk(clk), .reset(reset),
    .ddr_rd_en(ddr_rd_en), .ddr_rd_ready(ddr_rd_ready), .ddr_rd_addr(ddr_rd_addr),
    .req_allowed(req_allowed), .exp_addr(exp_addr),
    .buf_rd_en(buf_rd_en), .buf_rd_data(buf_rd_data), .exp_data(exp_data),
    .error_count(chk_errors)
  );

  // in-order returns with random latency in rand_mode
  always @(posedge clk) begin
    if (reset) begin
      ddr_rd_ready <= 1'b0;
      ddr_rd_valid <= 1'b0;
    end else begin
      if ((ret_q.size() > 0) && (!rand_mode || ($urandom % 4 == 0))) begin
        ddr_rd_valid <= 1'b1;
        ddr_rd_data  <= mem_word(ret_q.pop_front());
      end else begin
        ddr_rd_valid <= 1'b0;
      end
      if (ddr_rd_en && ddr_rd_ready) begin
        ret_q.push_back(ddr_rd_addr);
        accepted <= accepted + 1;
      end
      ddr_rd_ready <= !rand_mode || ($urandom % 2 == 0);
    end
  end

  always @(posedge clk) begin
    if (buf_rd_en) begin
      rd_ref <= buf_rd_addr;
    end
  end

  ////////////////////////////////////////
  // apb and load tasks
  ////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [`WLOAD_APB_ADDR_W-1:0] addr,
                            input logic [31:0] data, output logic [31:0] rd,
                            output logic slverr);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pready && (n < APB_TIMEOUT));
    if (!pready) begin
      $display("%0t: apb access to %h never got pready", $time, addr);
      tb_errors++;
    end
    rd      = prdata;
    slverr  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [`WLOAD_APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    if (err !== exp_err) begin
      $display("[ERROR] %0t pslverr expected %b actual %b", $time, exp_err, err);
      tb_errors++;
    end
  endtask

  task automatic reg_check(input logic [`WLOAD_APB_ADDR_W-1:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    if (rd !== exp) begin
      $display("[ERROR] %0t prdata at %h expected %h actual %h", $time, addr, exp, rd);
      tb_errors++;
    end
  endtask

  task automatic set_layer(input int nkk, input int of, input wload_pkg::ddr_addr_t base);
    cur_nkk  <= nkk;
    cur_of   <= of;
    cur_base <= base;
    reg_write(`WLOAD_REG_NKK, nkk, 1'b0);
    reg_write(`WLOAD_REG_OF, of, 1'b0);
    reg_write(`WLOAD_REG_BASE, base, 1'b0);
    reg_check(`WLOAD_REG_NKK, nkk);
    reg_check(`WLOAD_REG_OF, of);
    reg_check(`WLOAD_REG_BASE, base);
  endtask

  task automatic begin_load(input logic mode);
    int rows;
    rows = mode ? `WLOAD_ROWS_MODE1 : `WLOAD_ROWS_MODE0;
    cur_tile   <= next_tile;
    idx_origin <= accepted;
    loading    <= 1'b1;
    // back to tile 0 once the next tile would pass the last channel
    if ((chan_start + rows) + rows > cur_of) begin
      chan_start = 0;
      next_tile  = 0;
    end else begin
      chan_start += rows;
      next_tile++;
    end
    reg_write(`WLOAD_REG_CTRL, {30'd0, mode, 1'b1}, 1'b0);
  endtask

  task automatic finish_load();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!load_done && (n < LOAD_TIMEOUT));
    if (!load_done) begin
      $display("%0t: load of tile %0d never reported done", $time, cur_tile);
      tb_errors++;
    end
    loading <= 1'b0;
    if (req_idx != cur_nkk) begin
      $display("[ERROR] %0t ddr_rd_en handshakes expected %0d actual %0d",
               $time, cur_nkk, req_idx);
      tb_errors++;
    end
    reg_check(`WLOAD_REG_STATUS, 32'h2);
    reg_write(`WLOAD_REG_STATUS, 32'h2, 1'b0);
    reg_check(`WLOAD_REG_STATUS, 32'h0);
    // whole tile back through the compute port
    for (n = 0; n < cur_nkk; n++) begin
      @(posedge clk);
      buf_rd_en   <= 1'b1;
      buf_rd_addr <= wload_pkg::buf_addr_t'(n);
    end
    @(posedge clk);
    buf_rd_en <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////

  initial begin
    int n;
    void'($urandom(SEED));
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    buf_rd_en   = 1'b0;
    buf_rd_addr = '0;
    rand_mode   = 1'b0;
    loading     = 1'b0;
    idx_origin  = 0;
    tb_errors   = 0;
    chan_start  = 0;
    next_tile   = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    if ((ddr_rd_en !== 1'b0) || (load_done !== 1'b0)) begin
      $display("%0t: ddr_rd_en or load_done is not low after reset", $time);
      tb_errors++;
    end
    for (n = 0; n <= `WLOAD_REG_STATUS; n += 4) begin
      reg_check(n[`WLOAD_APB_ADDR_W-1:0], 32'd0);
    end

    // bad starts are refused
    reg_write(`WLOAD_REG_CTRL, 32'h1, 1'b1);
    reg_write(`WLOAD_REG_NKK, `WLOAD_BUF_DEPTH + 1, 1'b0);
    reg_write(`WLOAD_REG_CTRL, 32'h1, 1'b1);

    // mode0 wraps after 3 tiles and mode1 after 2
    set_layer(16, 192, 32'h0000_1000);
    repeat (6) begin
      begin_load(1'b0);
      finish_load();
    end
    set_layer(16, 256, 32'h0004_0000);
    repeat (4) begin
      begin_load(1'b1);
      finish_load();
    end

    // random ready and latency with tiles longer than the queue
    rand_mode <= 1'b1;
    set_layer(40, 128, 32'h0002_0000);
    repeat (4) begin
      begin_load(1'b0);
      finish_load();
    end
    set_layer(40, 384, 32'h0010_0100);
    repeat (6) begin
      begin_load(1'b1);
      finish_load();
    end

    // second start during a load
    begin_load(1'b0);
    reg_write(`WLOAD_REG_CTRL, 32'h1, 1'b1);
    finish_load();

    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if ((chk_errors + tb_errors) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
design/wload_pkg.sv
design/wload_apb_regs.sv
design/conv_load_weights_controller.sv
design/ddr_req_fifo.sv
design/weight_buffer.sv
design/wload_top.sv
testbench/wload_checker.sv
testbench/wload_tb.sv
